// ==== gpio_pinmap.svh ====
// Pad index map of the handheld console board, one bit position per named pad
`ifndef GPIO_PINMAP_SVH
`define GPIO_PINMAP_SVH

localparam int PIN_UART_TX    = 0;
localparam int PIN_UART_RX    = 1;
localparam int PIN_UART_RTS   = 2;
localparam int PIN_UART_CTS   = 3;
localparam int PIN_FLASH_MISO = 4;
localparam int PIN_FLASH_MOSI = 5;
localparam int PIN_FLASH_SCLK = 6;
localparam int PIN_FLASH_CS   = 7;
// Board inputs with pullups that are never driven
localparam int PIN_DPAD_U     = 8;
localparam int PIN_DPAD_D     = 9;
localparam int PIN_DPAD_L     = 10;
localparam int PIN_DPAD_R     = 11;
localparam int PIN_BTN_A      = 12;
localparam int PIN_LED        = 13;

`endif

// ==== gpio_pkg.sv ====
// Shared widths, register map, command structs and pin map of the GPIO subsystem
package gpio_pkg;

	`include "gpio_pinmap.svh"

	localparam int N_PADS = 14;
	typedef logic [N_PADS-1:0] pad_vec_t;

	// D-pad and button A are physically input only
	localparam pad_vec_t INPUT_ONLY_MASK = (N_PADS'(1) << PIN_DPAD_U) | (N_PADS'(1) << PIN_DPAD_D)
		| (N_PADS'(1) << PIN_DPAD_L) | (N_PADS'(1) << PIN_DPAD_R) | (N_PADS'(1) << PIN_BTN_A);

	localparam int W_ADDR = 8;
	localparam int W_DATA = 32;
	localparam int W_STRB = W_DATA / 8;

	localparam logic [W_ADDR-1:0] REG_OUT     = 8'h00;
	localparam logic [W_ADDR-1:0] REG_OE      = 8'h04;
	localparam logic [W_ADDR-1:0] REG_IN      = 8'h08;
	localparam logic [W_ADDR-1:0] REG_OUT_SET = 8'h0C;
	localparam logic [W_ADDR-1:0] REG_OUT_CLR = 8'h10;
	localparam logic [W_ADDR-1:0] REG_OUT_TGL = 8'h14;

	localparam int RESET_HOLD = 8;
	localparam int W_HOLD_CNT = $clog2(RESET_HOLD + 1);

	typedef enum logic [2:0] {
		SEL_OUT, SEL_OE, SEL_IN, SEL_OUT_SET, SEL_OUT_CLR, SEL_OUT_TGL, SEL_NONE
	} reg_sel_t;

	typedef struct packed {
		logic              valid;
		reg_sel_t          sel;
		logic [W_DATA-1:0] data;
		logic [W_STRB-1:0] strb;
	} wr_cmd_t;

	typedef struct packed {
		logic     valid;
		reg_sel_t sel;
	} rd_req_t;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_t;

endpackage

// ==== gpio_reset_gen.sv ====
// Reset stretcher that synchronises the board reset and holds it after release
`timescale 1ns/1ps

module gpio_reset_gen (
	input  logic clk_sys,
	input  logic arst_n,
	output logic rst_n
);
	import gpio_pkg::*;

	logic [1:0]            sync_q;
	logic [W_HOLD_CNT-1:0] cnt_q;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= 2'b00;
			cnt_q  <= '0;
			rst_n  <= 1'b0;
		end else begin
			sync_q <= {sync_q[0], 1'b1};
			// Count only once the release has crossed the synchroniser
			if (sync_q[1] && !rst_n) begin
				if (cnt_q == W_HOLD_CNT'(RESET_HOLD - 1))
					rst_n <= 1'b1;
				else
					cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	// Release comes no earlier than the full stretch after arst_n rises
	a_no_early_release: assert property (@(posedge clk_sys)
		$rose(rst_n) |-> arst_n && $past(arst_n, RESET_HOLD + 2));

endmodule

// ==== gpio_axil_decode.sv ====
// AXI4-Lite front end that accepts bus transfers and decodes them into register commands
`timescale 1ns/1ps

module gpio_axil_decode (
	input  logic                          clk_sys,
	input  logic                          rst_n,
	input  logic [gpio_pkg::W_ADDR-1:0]   awaddr,
	input  logic                          awvalid,
	output logic                          awready,
	input  logic [gpio_pkg::W_DATA-1:0]   wdata,
	input  logic [gpio_pkg::W_STRB-1:0]   wstrb,
	input  logic                          wvalid,
	output logic                          wready,
	input  logic [gpio_pkg::W_ADDR-1:0]   araddr,
	input  logic                          arvalid,
	output logic                          arready,
	input  logic                          b_free,
	input  logic                          r_free,
	output gpio_pkg::wr_cmd_t             wr_cmd,
	output gpio_pkg::rd_req_t             rd_req
);
	import gpio_pkg::*;

	function automatic reg_sel_t decode_sel(input logic [W_ADDR-1:0] addr, input logic is_wr);
		reg_sel_t sel;
		case (addr)
			REG_OUT:     sel = SEL_OUT;
			REG_OE:      sel = SEL_OE;
			// IN is read only so a write lands in a hole
			REG_IN:      sel = is_wr ? SEL_NONE : SEL_IN;
			REG_OUT_SET: sel = SEL_OUT_SET;
			REG_OUT_CLR: sel = SEL_OUT_CLR;
			REG_OUT_TGL: sel = SEL_OUT_TGL;
			default:     sel = SEL_NONE;
		endcase
		return sel;
	endfunction

	logic wr_go;
	logic rd_go;

	// Address and data are taken together with one transfer per free slot
	assign wr_go = awvalid && wvalid && b_free && !wr_cmd.valid;
	assign rd_go = arvalid && r_free && !rd_req.valid;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			wr_cmd <= '0;
			rd_req <= '0;
		end else begin
			wr_cmd.valid <= wr_go;
			if (wr_go) begin
				wr_cmd.sel  <= decode_sel(awaddr, 1'b1);
				wr_cmd.data <= wdata;
				wr_cmd.strb <= wstrb;
			end
			rd_req.valid <= rd_go;
			if (rd_go)
				rd_req.sel <= decode_sel(araddr, 1'b0);
		end
	end

	// Ready pulses coincide with the registered command
	assign awready = wr_cmd.valid;
	assign wready  = wr_cmd.valid;
	assign arready = rd_req.valid;

	// The committed transfer is still offered and its response slot is still empty
	a_wr_slot: assert property (@(posedge clk_sys) disable iff (!rst_n)
		awready |-> awvalid && wvalid && b_free);
	a_rd_slot: assert property (@(posedge clk_sys) disable iff (!rst_n)
		arready |-> arvalid && r_free);

endmodule

// ==== gpio_regs.sv ====
// Execute stage holding the OUT and OE registers and applying decoded write commands
`timescale 1ns/1ps

module gpio_regs (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  gpio_pkg::wr_cmd_t  wr_cmd,
	output gpio_pkg::pad_vec_t out_q,
	output gpio_pkg::pad_vec_t oe_q
);
	import gpio_pkg::*;

	// Expand byte strobes to one enable per pad bit
	function automatic pad_vec_t strb_mask(input logic [W_STRB-1:0] strb);
		pad_vec_t m;
		for (int i = 0; i < N_PADS; i++)
			m[i] = strb[i / 8];
		return m;
	endfunction

	pad_vec_t wbits;
	pad_vec_t wmask;
	pad_vec_t out_d;
	pad_vec_t oe_d;

	assign wbits = wr_cmd.data[N_PADS-1:0];
	assign wmask = strb_mask(wr_cmd.strb);

	always_comb begin
		out_d = out_q;
		oe_d  = oe_q;
		if (wr_cmd.valid) begin
			case (wr_cmd.sel)
				SEL_OUT:     out_d = (out_q & ~wmask) | (wbits & wmask);
				SEL_OUT_SET: out_d = out_q | (wbits & wmask);
				SEL_OUT_CLR: out_d = out_q & ~(wbits & wmask);
				SEL_OUT_TGL: out_d = out_q ^ (wbits & wmask);
				// Input-only pads can never be enabled
				SEL_OE:      oe_d  = ((oe_q & ~wmask) | (wbits & wmask)) & ~INPUT_ONLY_MASK;
				default:     ;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			out_q <= '0;
			oe_q  <= '0;
		end else begin
			out_q <= out_d;
			oe_q  <= oe_d;
		end
	end

	a_oe_input_only: assert property (@(posedge clk_sys) (oe_q & INPUT_ONLY_MASK) == '0);

endmodule

// ==== gpio_axil_result.sv ====
// Write and read response stage with the readback mux and response holding
`timescale 1ns/1ps

module gpio_axil_result (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  gpio_pkg::wr_cmd_t           wr_cmd,
	input  gpio_pkg::rd_req_t           rd_req,
	input  gpio_pkg::pad_vec_t          out_q,
	input  gpio_pkg::pad_vec_t          oe_q,
	input  gpio_pkg::pad_vec_t          in_sync,
	output gpio_pkg::resp_t             bresp,
	output logic                        bvalid,
	input  logic                        bready,
	output logic [gpio_pkg::W_DATA-1:0] rdata,
	output gpio_pkg::resp_t             rresp,
	output logic                        rvalid,
	input  logic                        rready,
	output logic                        b_free,
	output logic                        r_free
);
	import gpio_pkg::*;

	logic [W_DATA-1:0] rd_mux;
	resp_t             rd_resp;

	always_comb begin
		rd_mux  = '0;
		rd_resp = RESP_OKAY;
		case (rd_req.sel)
			SEL_OUT:  rd_mux = W_DATA'(out_q);
			SEL_OE:   rd_mux = W_DATA'(oe_q);
			SEL_IN:   rd_mux = W_DATA'(in_sync);
			SEL_NONE: rd_resp = RESP_SLVERR;
			// Set, clear and toggle read back as zero
			default:  ;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			bvalid <= wr_cmd.valid || (bvalid && !bready);
			rvalid <= rd_req.valid || (rvalid && !rready);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_cmd.valid)
			bresp <= (wr_cmd.sel == SEL_NONE) ? RESP_SLVERR : RESP_OKAY;
		if (rd_req.valid) begin
			rdata <= rd_mux;
			rresp <= rd_resp;
		end
	end

	assign b_free = !bvalid;
	assign r_free = !rvalid;

	a_rdata_hold: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rvalid && !rready |=> $stable(rdata));

endmodule

// ==== gpio_pad_bank.sv ====
// Pad drive registers and the synchronised readback of every pad
`timescale 1ns/1ps

module gpio_pad_bank (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  gpio_pkg::pad_vec_t out_q,
	input  gpio_pkg::pad_vec_t oe_q,
	input  gpio_pkg::pad_vec_t pad_in,
	output gpio_pkg::pad_vec_t pad_out,
	output gpio_pkg::pad_vec_t pad_oe,
	output gpio_pkg::pad_vec_t in_sync
);
	import gpio_pkg::*;

	pad_vec_t pad_rb;
	pad_vec_t sync_q;

	// A driven pad sees its own output level
	assign pad_rb = (pad_oe & pad_out) | (~pad_oe & pad_in);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			pad_out <= '0;
			pad_oe  <= '0;
		end else begin
			pad_out <= out_q;
			pad_oe  <= oe_q;
		end
	end

	// Two flop synchroniser on the asynchronous pad levels
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			sync_q  <= '0;
			in_sync <= '0;
		end else begin
			sync_q  <= pad_rb;
			in_sync <= sync_q;
		end
	end

endmodule

// ==== gpio_subsystem.sv ====
// GPIO pad subsystem top with AXI4-Lite register access and the activity LEDs
`timescale 1ns/1ps

module gpio_subsystem (
	input  logic                        clk_sys,
	input  logic                        arst_n,
	input  logic [gpio_pkg::W_ADDR-1:0] awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [gpio_pkg::W_DATA-1:0] wdata,
	input  logic [gpio_pkg::W_STRB-1:0] wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output gpio_pkg::resp_t             bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  logic [gpio_pkg::W_ADDR-1:0] araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [gpio_pkg::W_DATA-1:0] rdata,
	output gpio_pkg::resp_t             rresp,
	output logic                        rvalid,
	input  logic                        rready,
	input  gpio_pkg::pad_vec_t          pad_in,
	output gpio_pkg::pad_vec_t          pad_out,
	output gpio_pkg::pad_vec_t          pad_oe,
	output logic [7:0]                  led
);
	import gpio_pkg::*;

	logic     rst_n;
	logic     b_free;
	logic     r_free;
	wr_cmd_t  wr_cmd;
	rd_req_t  rd_req;
	pad_vec_t out_q;
	pad_vec_t oe_q;
	pad_vec_t in_sync;

	gpio_reset_gen i_gpio_reset_gen (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.rst_n   (rst_n)
	);

	gpio_axil_decode i_gpio_axil_decode (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.b_free  (b_free),
		.r_free  (r_free),
		.wr_cmd  (wr_cmd),
		.rd_req  (rd_req)
	);

	gpio_regs i_gpio_regs (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.wr_cmd  (wr_cmd),
		.out_q   (out_q),
		.oe_q    (oe_q)
	);

	gpio_axil_result i_gpio_axil_result (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.wr_cmd  (wr_cmd),
		.rd_req  (rd_req),
		.out_q   (out_q),
		.oe_q    (oe_q),
		.in_sync (in_sync),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.b_free  (b_free),
		.r_free  (r_free)
	);

	gpio_pad_bank i_gpio_pad_bank (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.out_q   (out_q),
		.oe_q    (oe_q),
		.pad_in  (pad_in),
		.pad_out (pad_out),
		.pad_oe  (pad_oe),
		.in_sync (in_sync)
	);

	// LED order follows the board with the UART lines shown active low
	assign led = {
		~pad_out[PIN_UART_TX],
		~in_sync[PIN_UART_RX],
		in_sync[PIN_DPAD_U],
		in_sync[PIN_DPAD_D],
		in_sync[PIN_DPAD_L],
		in_sync[PIN_DPAD_R],
		in_sync[PIN_BTN_A],
		pad_out[PIN_LED] & pad_oe[PIN_LED]
	};

endmodule

// ==== tb_clock_gen.sv ====
// Free running testbench clock source for the GPIO subsystem
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 40
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== tb_gpio_subsystem.sv ====
// Testbench for the GPIO subsystem with random AXI4-Lite traffic against a register and pad model
`timescale 1ns/1ps

module tb_gpio_subsystem;
	import gpio_pkg::*;

	localparam int CLK_PERIOD_NS = 40;
	localparam int SEED          = 6626;
	localparam int RESET_CYCLES  = 4;
	localparam int N_LOOP        = 24;
	// Bus transactions issued per loop pass over all sections
	localparam int N_TXN         = N_LOOP * 18;
	localparam int TXN_CYCLES    = 24;
	localparam int TIMEOUT_NS    =
		(N_TXN * TXN_CYCLES + RESET_CYCLES + RESET_HOLD + 20) * CLK_PERIOD_NS;

	logic              clk_sys;
	logic              arst_n;
	logic [W_ADDR-1:0] awaddr;
	logic              awvalid;
	logic              awready;
	logic [W_DATA-1:0] wdata;
	logic [W_STRB-1:0] wstrb;
	logic              wvalid;
	logic              wready;
	resp_t             bresp;
	logic              bvalid;
	logic              bready;
	logic [W_ADDR-1:0] araddr;
	logic              arvalid;
	logic              arready;
	logic [W_DATA-1:0] rdata;
	resp_t             rresp;
	logic              rvalid;
	logic              rready;
	pad_vec_t          pad_in;
	pad_vec_t          pad_out;
	pad_vec_t          pad_oe;
	logic [7:0]        led;

	// Register model
	pad_vec_t m_out;
	pad_vec_t m_oe;

	logic [W_ADDR-1:0] reg_addrs [6] = '{REG_OUT, REG_OE, REG_IN, REG_OUT_SET, REG_OUT_CLR,
		REG_OUT_TGL};

	tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) i_tb_clock_gen (.clk(clk_sys));

	gpio_subsystem i_gpio_subsystem (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.pad_in  (pad_in),
		.pad_out (pad_out),
		.pad_oe  (pad_oe),
		.led     (led)
	);

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("TB FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_data(input string name, input pad_vec_t got, input pad_vec_t exp);
		if (got !== exp)
			abort_run($sformatf("FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic check_resp(input string name, input resp_t got, input resp_t exp);
		if (got !== exp)
			abort_run($sformatf("FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic check_led(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			abort_run($sformatf("FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// Each strobe bit enables one byte lane of the data word
	function automatic pad_vec_t strb_bits(input logic [W_STRB-1:0] strb);
		logic [W_DATA-1:0] m;
		m = '0;
		for (int b = 0; b < W_STRB; b++)
			if (strb[b])
				m[b*8 +: 8] = 8'hFF;
		return m[N_PADS-1:0];
	endfunction

	// Driven pads read back their own level and the rest read the board
	function automatic pad_vec_t expected_in();
		return (m_oe & m_out) | (~m_oe & pad_in);
	endfunction

	function automatic logic [7:0] expected_led(input pad_vec_t pins);
		return {~m_out[PIN_UART_TX], ~pins[PIN_UART_RX], pins[PIN_DPAD_U], pins[PIN_DPAD_D],
			pins[PIN_DPAD_L], pins[PIN_DPAD_R], pins[PIN_BTN_A],
			m_out[PIN_LED] & m_oe[PIN_LED]};
	endfunction

	function automatic logic [W_ADDR-1:0] unknown_addr();
		logic [W_ADDR-1:0] a;
		do
			a = W_ADDR'($urandom);
		while (a inside {REG_OUT, REG_OE, REG_IN, REG_OUT_SET, REG_OUT_CLR, REG_OUT_TGL});
		return a;
	endfunction

	function automatic logic [W_ADDR-1:0] pick_addr();
		int k;
		k = $urandom_range(6, 0);
		if (k == 6)
			return unknown_addr();
		return reg_addrs[k];
	endfunction

	function automatic logic [W_ADDR-1:0] pick_bit_op();
		int k;
		k = 3 + $urandom_range(2, 0);
		return reg_addrs[k];
	endfunction

	task automatic axil_write(input logic [W_ADDR-1:0] addr, input logic [W_DATA-1:0] data,
		input logic [W_STRB-1:0] strb, input int max_stall, output resp_t resp);
		int n;
		n = $urandom_range(max_stall, 0);
		@(posedge clk_sys);
		awaddr  <= addr;
		wdata   <= data;
		wstrb   <= strb;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		@(negedge clk_sys);
		while (!(awready && wready))
			@(negedge clk_sys);
		@(posedge clk_sys);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		@(negedge clk_sys);
		while (!bvalid)
			@(negedge clk_sys);
		resp = bresp;
		// Response must hold while bready stays low
		repeat (n) begin
			@(negedge clk_sys);
			if (!bvalid)
				abort_run("write response dropped before bready");
			check_resp("bresp held", bresp, resp);
		end
		@(posedge clk_sys);
		bready <= 1'b1;
		@(posedge clk_sys);
		bready <= 1'b0;
		@(negedge clk_sys);
		if (bvalid)
			abort_run("write response repeated after its handshake");
	endtask

	task automatic axil_read(input logic [W_ADDR-1:0] addr, input int max_stall,
		output logic [W_DATA-1:0] data, output resp_t resp);
		int n;
		n = $urandom_range(max_stall, 0);
		@(posedge clk_sys);
		araddr  <= addr;
		arvalid <= 1'b1;
		@(negedge clk_sys);
		while (!arready)
			@(negedge clk_sys);
		@(posedge clk_sys);
		arvalid <= 1'b0;
		@(negedge clk_sys);
		while (!rvalid)
			@(negedge clk_sys);
		data = rdata;
		resp = rresp;
		repeat (n) begin
			@(negedge clk_sys);
			if (!rvalid)
				abort_run("read response dropped before rready");
			check_data("rdata held", rdata[N_PADS-1:0], data[N_PADS-1:0]);
			check_resp("rresp held", rresp, resp);
		end
		@(posedge clk_sys);
		rready <= 1'b1;
		@(posedge clk_sys);
		rready <= 1'b0;
		@(negedge clk_sys);
		if (rvalid)
			abort_run("read response repeated after its handshake");
	endtask

	task automatic write_reg(input logic [W_ADDR-1:0] addr, input logic [W_DATA-1:0] data,
		input logic [W_STRB-1:0] strb, input int max_stall);
		pad_vec_t bits;
		resp_t    resp;
		resp_t    exp_resp;
		bits     = data[N_PADS-1:0] & strb_bits(strb);
		exp_resp = RESP_OKAY;
		axil_write(addr, data, strb, max_stall, resp);
		case (addr)
			REG_OUT:     m_out = (m_out & ~strb_bits(strb)) | bits;
			REG_OE:      m_oe  = ((m_oe & ~strb_bits(strb)) | bits) & ~INPUT_ONLY_MASK;
			REG_OUT_SET: m_out = m_out | bits;
			REG_OUT_CLR: m_out = m_out & ~bits;
			REG_OUT_TGL: m_out = m_out ^ bits;
			default:     exp_resp = RESP_SLVERR;
		endcase
		check_resp("bresp", resp, exp_resp);
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check_data("pad_out", pad_out, m_out);
		check_data("pad_oe", pad_oe, m_oe);
	endtask

	task automatic read_reg(input logic [W_ADDR-1:0] addr, input int max_stall);
		logic [W_DATA-1:0] data;
		resp_t             resp;
		pad_vec_t          exp_data;
		resp_t             exp_resp;
		exp_data = '0;
		exp_resp = RESP_OKAY;
		case (addr)
			REG_OUT:                               exp_data = m_out;
			REG_OE:                                exp_data = m_oe;
			REG_IN:                                exp_data = expected_in();
			REG_OUT_SET, REG_OUT_CLR, REG_OUT_TGL: exp_data = '0;
			default:                               exp_resp = RESP_SLVERR;
		endcase
		axil_read(addr, max_stall, data, resp);
		check_resp("rresp", resp, exp_resp);
		check_data("rdata", data[N_PADS-1:0], exp_data);
		if (data[W_DATA-1:N_PADS] != '0)
			abort_run($sformatf("FAILED rdata upper bits got 0x%0h expected 0x0",
				data[W_DATA-1:N_PADS]));
	endtask

	// Input-only pads are never driven
	always @(negedge clk_sys)
		if (arst_n)
			check_data("pad_oe input-only bits", pad_oe & INPUT_ONLY_MASK, '0);

	initial begin
		#(TIMEOUT_NS);
		abort_run("watchdog timeout, a bus handshake never completed");
	end

	initial begin
		void'($urandom(SEED));
		arst_n   = 1'b0;
		awaddr   = '0;
		awvalid  = 1'b0;
		wdata    = '0;
		wstrb    = '0;
		wvalid   = 1'b0;
		bready   = 1'b0;
		araddr   = '0;
		arvalid  = 1'b0;
		rready   = 1'b0;
		pad_in   = '0;
		m_out    = '0;
		m_oe     = '0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		arst_n <= 1'b1;
		pad_in <= N_PADS'($urandom);
		// Internal reset is still stretched at this point
		@(negedge clk_sys);
		check_data("pad_out", pad_out, '0);
		check_data("pad_oe", pad_oe, '0);
		if (awready || wready || arready || bvalid || rvalid)
			abort_run("bus handshake output active during the internal reset");

		// Plain OUT and OE writes with random strobes
		for (int i = 0; i < N_LOOP; i++) begin
			write_reg(REG_OUT, $urandom, W_STRB'($urandom), 3);
			write_reg(REG_OE, $urandom, W_STRB'($urandom), 3);
			read_reg(REG_OUT, 3);
			read_reg(REG_OE, 3);
		end

		// Set, clear and toggle, and write-only readback
		for (int i = 0; i < N_LOOP; i++) begin
			write_reg(pick_bit_op(), $urandom, W_STRB'($urandom), 3);
			read_reg(REG_OUT, 3);
			read_reg(pick_bit_op(), 3);
		end

		// Pad readback and LEDs with new board levels
		for (int i = 0; i < N_LOOP; i++) begin
			write_reg(REG_OE, $urandom, 4'hF, 2);
			write_reg(REG_OUT, $urandom, 4'hF, 2);
			@(posedge clk_sys);
			pad_in <= N_PADS'($urandom);
			repeat (4) @(posedge clk_sys);
			@(negedge clk_sys);
			check_led("led", led, expected_led(expected_in()));
			read_reg(REG_IN, 2);
		end

		// Error responses leave the state alone
		for (int i = 0; i < N_LOOP; i++) begin
			write_reg(unknown_addr(), $urandom, W_STRB'($urandom), 2);
			write_reg(REG_IN, $urandom, 4'hF, 2);
			read_reg(unknown_addr(), 2);
			read_reg(REG_OUT, 2);
			read_reg(REG_OE, 2);
		end

		// Mixed traffic with long response stalls
		for (int i = 0; i < N_LOOP; i++) begin
			write_reg(pick_addr(), $urandom, W_STRB'($urandom), 8);
			read_reg(pick_addr(), 8);
			read_reg(REG_IN, 8);
		end

		repeat (2) @(posedge clk_sys);
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+.
gpio_pkg.sv
gpio_reset_gen.sv
gpio_axil_decode.sv
gpio_regs.sv
gpio_axil_result.sv
gpio_pad_bank.sv
gpio_subsystem.sv
tb_clock_gen.sv
tb_gpio_subsystem.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_gpio_subsystem
FILELIST  := filelist.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(filter-out +incdir+%,$(shell cat $(FILELIST))) gpio_pinmap.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
